// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - src/rv_exec_pkg.sv
  - src/instr_decode.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/axil_exec_slave.sv
  - src/rv_exec_top.sv
  - target: test
    files:
      - tb/tb_rv_exec.sv

// ==== all.f ====
src/rv_exec_pkg.sv
src/instr_decode.sv
src/reg_file.sv
src/alu.sv
src/axil_exec_slave.sv
src/rv_exec_top.sv
tb/tb_rv_exec.sv

// ==== src/alu.sv ====
// integer ALU for the execute core, operand B from rs2 or the decoded immediate
`timescale 1ns/1ns

module alu import rv_exec_pkg::*; (
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    input  logic [31:0] imm_i,
    input  logic        use_imm_i,
    input  logic [3:0]  alu_op_i,
    output logic [31:0] result_o
);

    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];   // shifts only look at the low 5 bits

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = rs1_data_i + op_b;
            ALU_SUB:    result_o = rs1_data_i - op_b;
            ALU_SLL:    result_o = rs1_data_i << shamt;
            ALU_SLT: begin
                result_o = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
            end
            ALU_SLTU:   result_o = {31'd0, rs1_data_i < op_b};
            ALU_XOR:    result_o = rs1_data_i ^ op_b;
            ALU_SRL:    result_o = rs1_data_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(rs1_data_i) >>> shamt);
            ALU_OR:     result_o = rs1_data_i | op_b;
            ALU_AND:    result_o = rs1_data_i & op_b;
            ALU_PASS_B: result_o = op_b;   // lui
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== src/axil_exec_slave.sv ====
// AXI4-Lite slave for the execute core: instruction writes issue to the core, reads return registers
`timescale 1ns/1ns

module axil_exec_slave import rv_exec_pkg::*; #(
    parameter int ADDR_W   = 12,
    parameter int NUM_REGS = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [31:0]       wdata_i,
    input  logic [3:0]        wstrb_i,     // ignored, full words assumed
    input  logic              wvalid_i,
    output logic              wready_o,
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,
    output logic              issue_o,
    output logic [31:0]       instr_o,
    output logic [4:0]        host_raddr_o,
    input  logic              illegal_i,
    input  logic [31:0]       host_rdata_i
);

    logic              live_q;     // goes high the cycle after reset
    logic              wr_hs;
    logic              wr_instr;
    logic              ar_hs;
    logic [ADDR_W-1:0] rd_off;
    logic              rd_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write channel, AW and W taken together

    assign wr_hs     = live_q && awvalid_i && wvalid_i && !bvalid_o;
    assign awready_o = wr_hs;
    assign wready_o  = wr_hs;
    assign wr_instr  = (awaddr_i == ADDR_W'(ADDR_INSTR));
    assign issue_o   = wr_hs && wr_instr;
    assign instr_o   = wdata_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read channel and register window decode

    assign ar_hs        = live_q && arvalid_i && !rvalid_o;
    assign arready_o    = live_q && !rvalid_o;
    assign rd_off       = araddr_i - ADDR_W'(ADDR_REG_BASE);
    assign rd_hit       = (araddr_i >= ADDR_W'(ADDR_REG_BASE))
                       && (rd_off[1:0] == 2'b00)
                       && (rd_off[ADDR_W-1:2] < NUM_REGS);
    assign host_raddr_o = rd_off[6:2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            live_q   <= 1'b0;
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            live_q <= 1'b1;
            if (wr_hs) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (ar_hs) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // response payloads, held while valid waits
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            bresp_o <= (wr_instr && !illegal_i) ? RESP_OKAY : RESP_SLVERR;
        end
        if (ar_hs) begin
            rdata_o <= rd_hit ? host_rdata_i : '0;
            rresp_o <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== src/instr_decode.sv ====
// combinational RV32I decoder: register indices, immediate, ALU op select and the illegal flag
`timescale 1ns/1ns

module instr_decode import rv_exec_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic [31:0] instr_i,
    output logic [4:0]  rs1_o,
    output logic [4:0]  rs2_o,
    output logic [4:0]  rd_o,
    output logic [31:0] imm_o,
    output logic        use_imm_o,
    output logic [3:0]  alu_op_o,
    output logic        illegal_o
);

    rv_instr_u instr;
    logic      bad_op;
    logic      use_rs1;
    logic      use_rs2;
    logic      bad_reg;

    assign instr = instr_i;
    assign rs1_o = instr.r.rs1;   // straight to the register file
    assign rs2_o = instr.r.rs2;
    assign rd_o  = instr.r.rd;

    always_comb begin
        bad_op    = 1'b0;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        use_imm_o = 1'b1;
        alu_op_o  = ALU_ADD;
        imm_o     = {{20{instr.i.imm12[11]}}, instr.i.imm12};  // sign-extended I imm
        case (instr.r.opcode)
            OPC_OP: begin
                use_rs2   = 1'b1;
                use_imm_o = 1'b0;
                case ({instr.r.funct7, instr.r.funct3})
                    {7'h00, 3'b000}: alu_op_o = ALU_ADD;
                    {7'h20, 3'b000}: alu_op_o = ALU_SUB;
                    {7'h00, 3'b001}: alu_op_o = ALU_SLL;
                    {7'h00, 3'b010}: alu_op_o = ALU_SLT;
                    {7'h00, 3'b011}: alu_op_o = ALU_SLTU;
                    {7'h00, 3'b100}: alu_op_o = ALU_XOR;
                    {7'h00, 3'b101}: alu_op_o = ALU_SRL;
                    {7'h20, 3'b101}: alu_op_o = ALU_SRA;
                    {7'h00, 3'b110}: alu_op_o = ALU_OR;
                    {7'h00, 3'b111}: alu_op_o = ALU_AND;
                    default:         bad_op   = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                case (instr.i.funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    3'b001: begin
                        alu_op_o = ALU_SLL;
                        bad_op   = (instr.i.imm12[11:5] != 7'h00);
                    end
                    default: begin
                        // srli/srai, imm[10] picks arithmetic
                        alu_op_o = instr.i.imm12[10] ? ALU_SRA : ALU_SRL;
                        bad_op   = ({instr.i.imm12[11], instr.i.imm12[9:5]} != 6'h00);
                    end
                endcase
            end
            OPC_LUI: begin
                use_rs1  = 1'b0;
                alu_op_o = ALU_PASS_B;
                imm_o    = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'h000};
            end
            default: bad_op = 1'b1;
        endcase
    end

    // only indices the instruction really names are checked (rv32e)
    assign bad_reg = (32'(rd_o) >= NUM_REGS)
                  || (use_rs1 && 32'(rs1_o) >= NUM_REGS)
                  || (use_rs2 && 32'(rs2_o) >= NUM_REGS);

    assign illegal_o = bad_op || bad_reg;

endmodule

// ==== src/reg_file.sv ====
// integer register file with x0 tied to zero, two operand read ports, a host port and one write port
`timescale 1ns/1ns

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    input  logic [4:0]  raddr3_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    output logic [31:0] rdata3_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [NUM_REGS];

    // x0 and indices past the array read as zero
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] val;
        val = '0;
        if (addr != 5'd0 && 32'(addr) < NUM_REGS) begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int n = 0; n < NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0 && 32'(waddr_i) < NUM_REGS) begin
            regs[waddr_i] <= wdata_i;   // x0 writes dropped
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
        rdata3_o = read_port(raddr3_i);   // host side
    end

endmodule

// ==== src/rv_exec_pkg.sv ====
// opcodes, ALU codes, address map and instruction layout, imported by the execute RTL and testbench
package rv_exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU operation codes
    localparam logic [3:0] ALU_ADD    = 4'd0;
    localparam logic [3:0] ALU_SUB    = 4'd1;
    localparam logic [3:0] ALU_SLL    = 4'd2;
    localparam logic [3:0] ALU_SLT    = 4'd3;
    localparam logic [3:0] ALU_SLTU   = 4'd4;
    localparam logic [3:0] ALU_XOR    = 4'd5;
    localparam logic [3:0] ALU_SRL    = 4'd6;
    localparam logic [3:0] ALU_SRA    = 4'd7;
    localparam logic [3:0] ALU_OR     = 4'd8;
    localparam logic [3:0] ALU_AND    = 4'd9;
    localparam logic [3:0] ALU_PASS_B = 4'd10;   // operand B straight through, for LUI

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite address map and responses
    localparam logic [11:0] ADDR_INSTR    = 12'h000;
    localparam logic [11:0] ADDR_REG_BASE = 12'h080;  // xn at base + 4*n

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } rv_instr_u;

endpackage

// ==== src/rv_exec_top.sv ====
// top of the RV32I execute subsystem: AXI4-Lite slave, decoder, register file and ALU
`timescale 1ns/1ns

module rv_exec_top #(
    parameter int ADDR_W   = 12,
    parameter int NUM_REGS = 32
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [31:0]       wdata_i,
    input  logic [3:0]        wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i
);

    logic        issue;
    logic [31:0] instr;
    logic        illegal;
    logic [4:0]  host_raddr;
    logic [31:0] host_rdata;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic [3:0]  alu_op;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] result;
    logic        reg_we;

    // decode and slave paths meet here
    assign reg_we = issue && !illegal;

    axil_exec_slave #(
        .ADDR_W   (ADDR_W),
        .NUM_REGS (NUM_REGS)
    ) u_slave (
        .*,                            // bus ports keep their names
        .issue_o      (issue),
        .instr_o      (instr),
        .host_raddr_o (host_raddr),
        .illegal_i    (illegal),
        .host_rdata_i (host_rdata)
    );

    instr_decode #(
        .NUM_REGS (NUM_REGS)
    ) u_decode (
        .instr_i   (instr),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .imm_o     (imm),
        .use_imm_o (use_imm),
        .alu_op_o  (alu_op),
        .illegal_o (illegal)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_regs (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .raddr3_i (host_raddr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .rdata3_o (host_rdata),
        .we_i     (reg_we),
        .waddr_i  (rd),
        .wdata_i  (result)
    );

    alu u_alu (
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .use_imm_i  (use_imm),
        .alu_op_i   (alu_op),
        .result_o   (result)
    );

endmodule

// ==== tb/tb_rv_exec.sv ====
// self-checking testbench that drives the RV32I execute subsystem over its AXI4-Lite port
`timescale 1ns/1ns

module tb_rv_exec import rv_exec_pkg::*; ();

    localparam int TIMEOUT = 64;   // cycles per wait loop

    logic        clk;
    logic        rst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] model [32];          // reference register file
    logic [31:0] seed       = 32'hce5c0244;
    int          data_errs  = 0;
    int          proto_errs = 0;
    int          timeouts   = 0;

    rv_exec_top #(
        .ADDR_W   (12),
        .NUM_REGS (32)
    ) dut0 (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake timing

    write_latency: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && awready |=> $rose(bvalid)) else begin
        proto_errs++;
        $display("bvalid did not rise one cycle after the write handshake");
    end

    read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> $rose(rvalid)) else begin
        proto_errs++;
        $display("rvalid did not rise one cycle after the read handshake");
    end

    write_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> !awready && !wready) else begin
        proto_errs++;
        $display("a write was accepted while a write response was pending");
    end

    read_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> !arready) else begin
        proto_errs++;
        $display("arready was high while a read response was pending");
    end

    bresp_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)) else begin
        proto_errs++;
        $display("write response dropped or changed before it was taken");
    end

    rresp_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)) else begin
        proto_errs++;
        $display("read response dropped or changed before it was taken");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};   // weak low bits moved up
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I result by funct3 where alt selects SUB or SRA
    function automatic logic [31:0] ref_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        rv_instr_u w;
        w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        rv_instr_u w;
        w.i = '{imm, rs1, f3, rd, opc};
        return w;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            data_errs++;
            $display("ERROR %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        int   n;
        logic hs;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n       = 0;
        hs      = 1'b0;
        while (!hs && n < TIMEOUT) begin
            @(negedge clk);
            hs = awready && wready;
            @(posedge clk);
            #1;
            n++;
        end
        if (!hs) begin
            timeouts++;
            $display("write to address %h was never accepted", addr);
        end
        repeat (hold) begin   // request left up and must not be taken again
            @(posedge clk);
            #1;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        resp    = 2'bxx;
        n       = 0;
        hs      = 1'b0;
        while (!hs && n < TIMEOUT) begin
            @(negedge clk);
            hs = bvalid;
            if (hs) begin
                resp = bresp;
            end
            @(posedge clk);
            #1;
            n++;
        end
        bready = 1'b0;
        if (!hs) begin
            timeouts++;
            $display("no write response came for address %h", addr);
        end
    endtask

    task automatic axi_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int   n;
        logic hs;
        araddr  = addr;
        arvalid = 1'b1;
        n       = 0;
        hs      = 1'b0;
        while (!hs && n < TIMEOUT) begin
            @(negedge clk);
            hs = arready;
            @(posedge clk);
            #1;
            n++;
        end
        if (!hs) begin
            timeouts++;
            $display("read of address %h was never accepted", addr);
        end
        repeat (hold) begin   // request stays up while rvalid waits
            @(posedge clk);
            #1;
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        data    = 'x;
        resp    = 2'bxx;
        n       = 0;
        hs      = 1'b0;
        while (!hs && n < TIMEOUT) begin
            @(negedge clk);
            hs = rvalid;
            if (hs) begin
                data = rdata;
                resp = rresp;
            end
            @(posedge clk);
            #1;
            n++;
        end
        rready = 1'b0;
        if (!hs) begin
            timeouts++;
            $display("no read response came for address %h", addr);
        end
    endtask

    task automatic issue(input string name, input logic [31:0] instr, input logic [1:0] exp);
        logic [1:0] resp;
        axi_write(ADDR_INSTR, instr, int'(lcg() % 8), resp);
        check_eq({name, " bresp"}, 32'(exp), 32'(resp));
    endtask

    task automatic check_reg(input string name, input logic [4:0] n);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(ADDR_REG_BASE + 12'(4 * n), int'(lcg() % 8), data, resp);
        check_eq($sformatf("%s x%0d", name, n), model[n], data);
        check_eq($sformatf("%s x%0d rresp", name, n), 32'(RESP_OKAY), 32'(resp));
    endtask

    // lui then addi so the value has random upper and lower parts
    task automatic load_reg(input logic [4:0] rd);
        logic [31:0] r;
        r = lcg();
        model[rd] = {r[31:12], 12'h000};
        issue("load lui", i_type(r[31:20], r[19:15], r[14:12], rd, OPC_LUI), RESP_OKAY);
        if (rd != 5'd0) begin
            model[rd] = model[rd] + sext12(r[11:0]);
        end
        issue("load addi", i_type(r[11:0], rd, 3'd0, rd, OPC_OP_IMM), RESP_OKAY);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic [1:0]  resp;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int n = 0; n < 32; n++) begin
            model[n] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        check_eq("reset arready", 32'd0, 32'(arready));
        rst_n = 1'b1;

        // reset state
        check_eq("reset bvalid", 32'd0, 32'(bvalid));
        check_eq("reset rvalid", 32'd0, 32'(rvalid));
        for (int n = 0; n < 32; n++) begin
            check_reg("reset", 5'(n));
        end
        axi_read(12'h040, 0, data, resp);
        check_eq("outside window rdata", 32'd0, data);
        check_eq("outside window rresp", 32'(RESP_SLVERR), 32'(resp));

        // register-register operations
        for (int n = 1; n < 32; n++) begin
            load_reg(5'(n));
        end
        for (int k = 0; k < 200; k++) begin
            r   = lcg();
            f3  = r[12:10];
            alt = r[13] && (f3 == 3'd0 || f3 == 3'd5);
            rd  = (r[18:14] == 5'd0) ? 5'd1 : r[18:14];
            model[rd] = ref_op(f3, alt, model[r[9:5]], model[r[4:0]]);
            issue("r-type", r_type(alt ? 7'h20 : 7'h00, r[4:0], r[9:5], f3, rd), RESP_OKAY);
            check_reg("r-type", rd);
            if (k % 25 == 24) begin
                load_reg(rd);   // keeps values from collapsing to 0 and 1
            end
        end

        // register-immediate operations and lui
        for (int k = 0; k < 100; k++) begin
            r   = lcg();
            rs1 = r[4:0];
            f3  = r[7:5];
            rd  = (r[12:8] == 5'd0) ? 5'd2 : r[12:8];
            imm = r[31:20];
            alt = 1'b0;
            if (f3 == 3'd1) begin
                imm = {7'h00, imm[4:0]};
            end else if (f3 == 3'd5) begin
                alt = imm[10];
                imm = {1'b0, alt, 5'h00, imm[4:0]};
            end
            model[rd] = ref_op(f3, alt, model[rs1], sext12(imm));
            issue("i-type", i_type(imm, rs1, f3, rd, OPC_OP_IMM), RESP_OKAY);
            check_reg("i-type", rd);
            if (k % 4 == 3) begin
                r = lcg();
                model[rd] = {r[19:0], 12'h000};
                issue("lui", i_type(r[19:8], r[7:3], r[2:0], rd, OPC_LUI), RESP_OKAY);
                check_reg("lui", rd);
            end
        end

        // x0 and rejected writes
        issue("addi x0", i_type(12'h7ff, 5'd1, 3'd0, 5'd0, OPC_OP_IMM), RESP_OKAY);
        check_reg("x0", 5'd0);
        issue("bad opcode", i_type(12'h004, 5'd1, 3'd0, 5'd2, 7'b1100011), RESP_SLVERR);
        issue("bad funct7", r_type(7'h01, 5'd3, 5'd4, 3'd0, 5'd5), RESP_SLVERR);
        issue("bad slli", i_type(12'h405, 5'd1, 3'd1, 5'd6, OPC_OP_IMM), RESP_SLVERR);
        axi_write(12'h004, i_type(12'h001, 5'd1, 3'd0, 5'd7, OPC_OP_IMM), 2, resp);
        check_eq("non-instruction address bresp", 32'(RESP_SLVERR), 32'(resp));
        for (int n = 0; n < 32; n++) begin
            check_reg("after rejected", 5'(n));
        end

        $display("errors: data %0d, protocol %0d, timeout %0d",
                 data_errs, proto_errs, timeouts);
        if (data_errs + proto_errs + timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
